// File: Bender.yml
package:
  name: dram_ctrl

sources:
  - files:
      - d_domain_pkg.sv
      - cmd_decoder.sv
      - dram_write_engine.sv
      - d2p_response_arbiter.sv
      - dram_ctrl_top.sv
  - target: test
    files:
      - tb_dram_ctrl_top.sv

// File: cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder #(
    parameter int config_words = 39
) (
    input  logic                              ui_clk,
    input  logic                              reset,
    input  logic                              init_calib_complete,
    input  d_domain_pkg::cmd_word_t           p2d_cmd,
    input  logic                              p2d_cmd_valid,
    input  d_domain_pkg::cmd_word_t           a2d_cmd,
    input  logic                              a2d_cmd_valid,
    input  logic                              d2a_full,
    input  logic [d_domain_pkg::COUNT_W-1:0]  write_count,
    input  logic                              grant,
    output logic                              p2d_cmd_rd_en,
    output logic                              a2d_cmd_rd_en,
    output logic                              d2a_wr_en,
    output d_domain_pkg::cmd_word_t           d2a_cmd,
    output d_domain_pkg::addr_range_t         addr_range,
    output logic                              range_load,
    output d_domain_pkg::resp_req_t           resp
);
    import d_domain_pkg::*;

    localparam int CNT_W = $clog2(config_words + 1);

    logic             calib_sent;
    logic [CNT_W-1:0] cfg_cnt;
    logic             cfg_full;
    logic [1:0]       addr_step;

    logic      is_config;
    logic      is_addr;
    logic      is_query;
    logic      calib_fire;
    logic      train_fire;
    logic      config_fire;
    logic      addr_word_fire;
    logic      ack_fire;
    logic      query_fire;
    logic      resp_fire;
    cmd_word_t resp_word;

    assign is_config = p2d_cmd_valid && (p2d_cmd.opcode == OP_CONFIG);
    assign is_addr   = p2d_cmd_valid && (p2d_cmd.opcode == OP_ADDR_SETUP);
    assign is_query  = p2d_cmd_valid && (p2d_cmd.opcode == OP_COUNT_QUERY);
    assign cfg_full  = (cfg_cnt == CNT_W'(config_words));

    // one response at a time, calibration notice first
    assign calib_fire = !resp.pending && init_calib_complete && !calib_sent;
    assign train_fire = !resp.pending && !calib_fire && a2d_cmd_valid
                      && (a2d_cmd.opcode == OP_TRAIN_DONE) && cfg_full;

    assign config_fire    = is_config && !d2a_full;
    // address words 1 to 3 need no response slot
    assign addr_word_fire = is_addr && (addr_step != 2'd3);
    assign ack_fire       = is_addr && (addr_step == 2'd3)
                          && !resp.pending && !calib_fire && !train_fire;
    assign query_fire     = is_query && !resp.pending && !calib_fire && !train_fire;

    assign p2d_cmd_rd_en = config_fire || addr_word_fire || ack_fire || query_fire;
    assign a2d_cmd_rd_en = train_fire;
    assign d2a_wr_en     = config_fire;
    assign d2a_cmd       = p2d_cmd;
    assign range_load    = ack_fire;
    assign resp_fire     = calib_fire || train_fire || ack_fire || query_fire;

    always_comb begin
        resp_word = '0;
        if (calib_fire) begin
            resp_word.opcode = OP_CALIB_DONE;
        end else if (train_fire) begin
            resp_word = a2d_cmd;
        end else if (ack_fire) begin
            resp_word.opcode = OP_ADDR_SETUP;
        end else begin
            resp_word.payload = write_count[PAYLOAD_W-1:0];
            resp_word.opcode  = OP_COUNT_QUERY;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            calib_sent   <= 1'b0;
            cfg_cnt      <= '0;
            addr_step    <= '0;
            resp.pending <= 1'b0;
        end else begin
            if (calib_fire) begin
                calib_sent <= 1'b1;
            end
            // training done clears, config words saturate
            if (train_fire) begin
                cfg_cnt <= '0;
            end else if (config_fire && !cfg_full) begin
                cfg_cnt <= cfg_cnt + 1'b1;
            end
            if (addr_word_fire || ack_fire) begin
                addr_step <= addr_step + 2'd1;
            end
            if (resp_fire) begin
                resp.pending <= 1'b1;
                resp.word    <= resp_word;
            end else if (grant) begin
                resp.pending <= 1'b0;
            end
        end
    end

    // 16-bit halves, base first then last
    always_ff @(posedge ui_clk) begin
        if (addr_word_fire || ack_fire) begin
            case (addr_step)
                2'd0:    addr_range.base[15:0]  <= p2d_cmd.payload[15:0];
                2'd1:    addr_range.base[31:16] <= p2d_cmd.payload[15:0];
                2'd2:    addr_range.last[15:0]  <= p2d_cmd.payload[15:0];
                default: addr_range.last[31:16] <= p2d_cmd.payload[15:0];
            endcase
        end
    end

    a_range_load_ack: assert property (
        @(posedge ui_clk) disable iff (reset)
        range_load |-> !resp.pending ##1 resp.pending
    );

    a_cfg_cnt_bound: assert property (
        @(posedge ui_clk) disable iff (reset)
        cfg_cnt <= CNT_W'(config_words)
    );

endmodule

// File: d2p_response_arbiter.sv
`timescale 1ns/1ps

module d2p_response_arbiter (
    input  logic                     ui_clk,
    input  logic                     reset,
    input  d_domain_pkg::resp_req_t  engine_req,
    input  d_domain_pkg::resp_req_t  decoder_req,
    input  logic                     d2p_full,
    output logic                     engine_grant,
    output logic                     decoder_grant,
    output logic                     d2p_wr_en,
    output d_domain_pkg::cmd_word_t  d2p_cmd
);
    import d_domain_pkg::*;

    // engine first, decoder waits its turn
    assign engine_grant  = engine_req.pending && !d2p_full;
    assign decoder_grant = decoder_req.pending && !d2p_full && !engine_req.pending;

    assign d2p_wr_en = engine_grant || decoder_grant;
    assign d2p_cmd   = engine_grant ? engine_req.word : decoder_req.word;

    a_one_grant: assert property (
        @(posedge ui_clk) disable iff (reset)
        !(engine_grant && decoder_grant)
    );

endmodule

// File: d_domain_pkg.sv
package d_domain_pkg;

    localparam int CMD_W             = 32;
    localparam int OPCODE_W          = 15;
    localparam int PAYLOAD_W         = 17;
    localparam int DATA_W            = 256;
    localparam int MASK_W            = DATA_W / 8;
    localparam int APP_ADDR_W        = 29;
    localparam int COUNT_W           = 32;
    // 256-bit beat is 32 bytes, 8 address units on a 32-bit DRAM
    localparam int BEAT_ADDR_STEP    = 8;
    localparam int CONFIG_WORD_COUNT = 39;

    typedef enum logic [OPCODE_W-1:0] {
        OP_CONFIG       = 15'd1,
        OP_TRAIN_DONE   = 15'd2,
        OP_CALIB_DONE   = 15'd3,
        OP_ADDR_SETUP   = 15'd4,
        OP_CHECK_REPORT = 15'd5,
        OP_COUNT_QUERY  = 15'd6
    } opcode_e;

    // opcode sits in the low bits of every command word
    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        logic [OPCODE_W-1:0]  opcode;
    } cmd_word_t;

    typedef enum logic [2:0] {
        APP_WRITE = 3'd0,
        APP_READ  = 3'd1
    } app_cmd_e;

    typedef struct packed {
        logic      pending;
        cmd_word_t word;
    } resp_req_t;

    typedef struct packed {
        logic [31:0] base;
        logic [31:0] last;
    } addr_range_t;

endpackage

// File: dram_ctrl_top.sv
`timescale 1ns/1ps

module dram_ctrl_top #(
    parameter int config_words = d_domain_pkg::CONFIG_WORD_COUNT,
    parameter int beat_step    = d_domain_pkg::BEAT_ADDR_STEP
) (
    input  logic                                 ui_clk,
    input  logic                                 reset,
    input  logic                                 init_calib_complete,

    // p2d command fifo
    output logic                                 fifo_p2d_command_rd_en,
    input  logic [d_domain_pkg::CMD_W-1:0]       fifo_p2d_command_dout,
    input  logic                                 fifo_p2d_command_empty,
    input  logic                                 fifo_p2d_command_valid,

    // p2d data fifo
    output logic                                 fifo_p2d_data_rd_en,
    input  logic [d_domain_pkg::DATA_W-1:0]      fifo_p2d_data_dout,
    input  logic                                 fifo_p2d_data_empty,
    input  logic                                 fifo_p2d_data_valid,

    // d2p command fifo
    output logic                                 fifo_d2p_command_wr_en,
    output logic [d_domain_pkg::CMD_W-1:0]       fifo_d2p_command_din,
    input  logic                                 fifo_d2p_command_full,

    // d2a command fifo
    output logic                                 fifo_d2a_command_wr_en,
    output logic [d_domain_pkg::CMD_W-1:0]       fifo_d2a_command_din,
    input  logic                                 fifo_d2a_command_full,

    // a2d command fifo
    output logic                                 fifo_a2d_command_rd_en,
    input  logic [d_domain_pkg::CMD_W-1:0]       fifo_a2d_command_dout,
    input  logic                                 fifo_a2d_command_empty,
    input  logic                                 fifo_a2d_command_valid,

    // memory controller application port
    output logic                                 app_en,
    output logic [2:0]                           app_cmd,
    output logic [d_domain_pkg::APP_ADDR_W-1:0]  app_addr,
    output logic                                 app_wdf_wren,
    output logic [d_domain_pkg::DATA_W-1:0]      app_wdf_data,
    output logic                                 app_wdf_end,
    output logic [d_domain_pkg::MASK_W-1:0]      app_wdf_mask,
    input  logic                                 app_rdy,
    input  logic                                 app_wdf_rdy,
    input  logic [d_domain_pkg::DATA_W-1:0]      app_rd_data,
    input  logic                                 app_rd_data_valid
);
    import d_domain_pkg::*;

    cmd_word_t          p2d_cmd;
    cmd_word_t          a2d_cmd;
    cmd_word_t          d2a_cmd;
    cmd_word_t          d2p_cmd;
    logic               p2d_cmd_valid;
    logic               a2d_cmd_valid;
    logic               p2d_data_valid;
    addr_range_t        addr_range;
    logic               range_load;
    logic [COUNT_W-1:0] write_count;
    resp_req_t          decoder_resp;
    resp_req_t          engine_resp;
    logic               decoder_grant;
    logic               engine_grant;
    app_cmd_e           engine_app_cmd;

    // word present only when valid and not empty
    assign p2d_cmd_valid  = fifo_p2d_command_valid && !fifo_p2d_command_empty;
    assign a2d_cmd_valid  = fifo_a2d_command_valid && !fifo_a2d_command_empty;
    assign p2d_data_valid = fifo_p2d_data_valid && !fifo_p2d_data_empty;

    assign p2d_cmd = cmd_word_t'(fifo_p2d_command_dout);
    assign a2d_cmd = cmd_word_t'(fifo_a2d_command_dout);

    assign fifo_d2a_command_din = d2a_cmd;
    assign fifo_d2p_command_din = d2p_cmd;
    assign app_cmd              = engine_app_cmd;

    cmd_decoder #(
        .config_words (config_words)
    ) u_cmd_decoder (
        .ui_clk              (ui_clk),
        .reset               (reset),
        .init_calib_complete (init_calib_complete),
        .p2d_cmd             (p2d_cmd),
        .p2d_cmd_valid       (p2d_cmd_valid),
        .a2d_cmd             (a2d_cmd),
        .a2d_cmd_valid       (a2d_cmd_valid),
        .d2a_full            (fifo_d2a_command_full),
        .write_count         (write_count),
        .grant               (decoder_grant),
        .p2d_cmd_rd_en       (fifo_p2d_command_rd_en),
        .a2d_cmd_rd_en       (fifo_a2d_command_rd_en),
        .d2a_wr_en           (fifo_d2a_command_wr_en),
        .d2a_cmd             (d2a_cmd),
        .addr_range          (addr_range),
        .range_load          (range_load),
        .resp                (decoder_resp)
    );

    dram_write_engine #(
        .beat_step (beat_step)
    ) u_dram_write_engine (
        .ui_clk            (ui_clk),
        .reset             (reset),
        .addr_range        (addr_range),
        .range_load        (range_load),
        .p2d_data          (fifo_p2d_data_dout),
        .p2d_data_valid    (p2d_data_valid),
        .app_rdy           (app_rdy),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .grant             (engine_grant),
        .p2d_data_rd_en    (fifo_p2d_data_rd_en),
        .app_en            (app_en),
        .app_cmd           (engine_app_cmd),
        .app_addr          (app_addr),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_end       (app_wdf_end),
        .app_wdf_mask      (app_wdf_mask),
        .write_count       (write_count),
        .resp              (engine_resp)
    );

    d2p_response_arbiter u_d2p_response_arbiter (
        .ui_clk        (ui_clk),
        .reset         (reset),
        .engine_req    (engine_resp),
        .decoder_req   (decoder_resp),
        .d2p_full      (fifo_d2p_command_full),
        .engine_grant  (engine_grant),
        .decoder_grant (decoder_grant),
        .d2p_wr_en     (fifo_d2p_command_wr_en),
        .d2p_cmd       (d2p_cmd)
    );

endmodule

// File: dram_write_engine.sv
`timescale 1ns/1ps

module dram_write_engine #(
    parameter int beat_step = 8
) (
    input  logic                                 ui_clk,
    input  logic                                 reset,
    input  d_domain_pkg::addr_range_t            addr_range,
    input  logic                                 range_load,
    input  logic [d_domain_pkg::DATA_W-1:0]      p2d_data,
    input  logic                                 p2d_data_valid,
    input  logic                                 app_rdy,
    input  logic                                 app_wdf_rdy,
    input  logic [d_domain_pkg::DATA_W-1:0]      app_rd_data,
    input  logic                                 app_rd_data_valid,
    input  logic                                 grant,
    output logic                                 p2d_data_rd_en,
    output logic                                 app_en,
    output d_domain_pkg::app_cmd_e               app_cmd,
    output logic [d_domain_pkg::APP_ADDR_W-1:0]  app_addr,
    output logic                                 app_wdf_wren,
    output logic [d_domain_pkg::DATA_W-1:0]      app_wdf_data,
    output logic                                 app_wdf_end,
    output logic [d_domain_pkg::MASK_W-1:0]      app_wdf_mask,
    output logic [d_domain_pkg::COUNT_W-1:0]     write_count,
    output d_domain_pkg::resp_req_t              resp
);
    import d_domain_pkg::*;

    typedef enum logic [1:0] {
        CHK_IDLE,
        CHK_READ,
        CHK_WAIT
    } chk_state_e;

    chk_state_e chk_state;

    logic [APP_ADDR_W-1:0] beat_addr;
    logic [APP_ADDR_W-1:0] last_addr;
    logic                  last_beat;
    logic                  beat_fire;
    logic                  read_fire;

    assign beat_addr = addr_range.base[APP_ADDR_W-1:0] + write_count[APP_ADDR_W-1:0];
    assign last_addr = addr_range.last[APP_ADDR_W-1:0];
    assign last_beat = (beat_addr == last_addr);

    // beats stall from the last beat until the report is granted
    assign beat_fire = (chk_state == CHK_IDLE) && !resp.pending
                     && p2d_data_valid && app_rdy && app_wdf_rdy;
    assign read_fire = (chk_state == CHK_READ) && app_rdy;

    assign p2d_data_rd_en = beat_fire;
    assign app_en         = beat_fire || read_fire;
    assign app_cmd        = read_fire ? APP_READ : APP_WRITE;
    assign app_addr       = read_fire ? last_addr : beat_addr;
    assign app_wdf_wren   = beat_fire;
    assign app_wdf_end    = beat_fire;
    assign app_wdf_data   = p2d_data;
    assign app_wdf_mask   = '0;

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            write_count  <= '0;
            chk_state    <= CHK_IDLE;
            resp.pending <= 1'b0;
        end else begin
            if (range_load) begin
                write_count <= '0;
            end else if (beat_fire) begin
                write_count <= write_count + COUNT_W'(beat_step);
            end

            case (chk_state)
                CHK_IDLE: begin
                    if (beat_fire && last_beat) begin
                        chk_state <= CHK_READ;
                    end
                end
                CHK_READ: begin
                    if (read_fire) begin
                        chk_state <= CHK_WAIT;
                    end
                end
                default: begin
                    if (app_rd_data_valid) begin
                        chk_state <= CHK_IDLE;
                    end
                end
            endcase

            // check report carries the low half-word read back
            if ((chk_state == CHK_WAIT) && app_rd_data_valid) begin
                resp.pending      <= 1'b1;
                resp.word.payload <= {1'b0, app_rd_data[15:0]};
                resp.word.opcode  <= OP_CHECK_REPORT;
            end else if (grant) begin
                resp.pending <= 1'b0;
            end
        end
    end

    a_wdf_with_write: assert property (
        @(posedge ui_clk) disable iff (reset)
        app_wdf_wren |-> app_en && (app_cmd == APP_WRITE) && app_wdf_rdy
    );

endmodule

// File: flist.f
d_domain_pkg.sv
cmd_decoder.sv
dram_write_engine.sv
d2p_response_arbiter.sv
dram_ctrl_top.sv
tb_dram_ctrl_top.sv

// File: tb_dram_ctrl_top.sv
`timescale 1ns/1ps

module tb_dram_ctrl_top;

    localparam int SRC_D2P        = 0;
    localparam int SRC_D2A        = 1;
    localparam int SRC_APP        = 2;
    localparam int TIMEOUT_CYCLES = 2000;

    logic         ui_clk;
    logic         reset;
    logic         init_calib_complete;
    logic         fifo_p2d_command_rd_en;
    logic [31:0]  fifo_p2d_command_dout;
    logic         fifo_p2d_command_empty;
    logic         fifo_p2d_command_valid;
    logic         fifo_p2d_data_rd_en;
    logic [255:0] fifo_p2d_data_dout;
    logic         fifo_p2d_data_empty;
    logic         fifo_p2d_data_valid;
    logic         fifo_d2p_command_wr_en;
    logic [31:0]  fifo_d2p_command_din;
    logic         fifo_d2p_command_full;
    logic         fifo_d2a_command_wr_en;
    logic [31:0]  fifo_d2a_command_din;
    logic         fifo_d2a_command_full;
    logic         fifo_a2d_command_rd_en;
    logic [31:0]  fifo_a2d_command_dout;
    logic         fifo_a2d_command_empty;
    logic         fifo_a2d_command_valid;
    logic         app_en;
    logic [2:0]   app_cmd;
    logic [28:0]  app_addr;
    logic         app_wdf_wren;
    logic [255:0] app_wdf_data;
    logic         app_wdf_end;
    logic [31:0]  app_wdf_mask;
    logic         app_rdy;
    logic         app_wdf_rdy;
    logic [255:0] app_rd_data;
    logic         app_rd_data_valid;

    // fifo and controller models
    logic [31:0]  p2d_cmd_q[$];
    logic [255:0] p2d_data_q[$];
    logic [31:0]  a2d_q[$];
    logic [31:0]  d2p_q[$];
    logic [31:0]  d2a_q[$];
    logic [2:0]   app_cmd_q[$];
    logic [28:0]  app_addr_q[$];
    logic [255:0] app_data_q[$];
    logic [255:0] read_word;
    integer       seed;
    int           errors;
    int           d2a_total;
    int           a2d_pop_level;
    int           read_delay;

    dram_ctrl_top u_dram_ctrl_top (.*);

    initial begin
        ui_clk = 1'b0;
        forever #10 ui_clk = ~ui_clk;
    end

    // fifo heads and controller ready lines change on the falling edge
    always @(negedge ui_clk) begin
        fifo_p2d_command_valid = p2d_cmd_q.size() > 0;
        fifo_p2d_command_empty = !fifo_p2d_command_valid;
        if (fifo_p2d_command_valid)
            fifo_p2d_command_dout = p2d_cmd_q[0];
        fifo_p2d_data_valid = p2d_data_q.size() > 0;
        fifo_p2d_data_empty = !fifo_p2d_data_valid;
        if (fifo_p2d_data_valid)
            fifo_p2d_data_dout = p2d_data_q[0];
        fifo_a2d_command_valid = a2d_q.size() > 0;
        fifo_a2d_command_empty = !fifo_a2d_command_valid;
        if (fifo_a2d_command_valid)
            fifo_a2d_command_dout = a2d_q[0];
        app_rdy           = ($random(seed) & 3) != 0;
        app_wdf_rdy       = ($random(seed) & 7) != 0;
        app_rd_data_valid = 1'b0;
        if (read_delay > 0) begin
            read_delay = read_delay - 1;
            if (read_delay == 0) begin
                app_rd_data_valid = 1'b1;
                app_rd_data       = read_word;
            end
        end
    end

    always @(posedge ui_clk) begin
        if (reset === 1'b0) begin
            if (fifo_p2d_command_rd_en && fifo_p2d_command_valid)
                p2d_cmd_q.delete(0);
            if (fifo_p2d_data_rd_en && fifo_p2d_data_valid)
                p2d_data_q.delete(0);
            // how many config words were forwarded before the a2d word left
            if (fifo_a2d_command_rd_en && fifo_a2d_command_valid) begin
                a2d_q.delete(0);
                a2d_pop_level = d2a_total;
            end
            if (fifo_d2a_command_wr_en) begin
                if (fifo_d2a_command_full) begin
                    errors = errors + 1;
                    $display("d2a FIFO written while full");
                end else begin
                    d2a_q.push_back(fifo_d2a_command_din);
                    d2a_total = d2a_total + 1;
                end
            end
            if (fifo_d2p_command_wr_en && !fifo_d2p_command_full)
                d2p_q.push_back(fifo_d2p_command_din);
            if (app_en && app_rdy) begin
                app_cmd_q.push_back(app_cmd);
                app_addr_q.push_back(app_addr);
                app_data_q.push_back(app_wdf_data);
                if (app_cmd == 3'd1) begin
                    read_delay = 3;
                end else if (!(app_wdf_wren && app_wdf_end && app_wdf_rdy)
                             || app_wdf_mask != '0) begin
                    errors = errors + 1;
                    $display("Write command accepted without its data beat or with a mask");
                end
            end
        end
    end

    task finish_run;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task check_value(input string name, input logic [255:0] expected,
                     input logic [255:0] actual);
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic int item_count(input int which);
        case (which)
            SRC_D2P: return d2p_q.size();
            SRC_D2A: return d2a_q.size();
            default: return app_cmd_q.size();
        endcase
    endfunction

    task automatic wait_items(input int which, input int n, input string what);
        int cycles;
        cycles = 0;
        while (item_count(which) < n && cycles < TIMEOUT_CYCLES) begin
            @(negedge ui_clk);
            cycles = cycles + 1;
        end
        if (item_count(which) < n) begin
            errors = errors + 1;
            $display("Timeout waiting for %s", what);
            finish_run();
        end
    endtask

    // opcode in the low 15 bits, payload above it
    function automatic logic [31:0] make_word(input logic [14:0] opcode,
                                              input logic [16:0] payload);
        return {payload, opcode};
    endfunction

    function automatic logic [31:0] config_word(input int k);
        logic [16:0] payload;
        payload = k * 2731 + 17;
        return make_word(15'd1, payload);
    endfunction

    function automatic logic [255:0] beat_pattern(input int k);
        logic [255:0] beat;
        int i;
        for (i = 0; i < 8; i++) begin
            beat[i*32 +: 32] = 32'h9e37_79b9 * (k + 1) + i * 32'h0101_0101;
        end
        return beat;
    endfunction

    task test_calib_notice;
        @(negedge ui_clk);
        init_calib_complete = 1'b1;
        wait_items(SRC_D2P, 1, "calibration notice");
        repeat (20) @(negedge ui_clk);
        check_value("calib notice count", 1, d2p_q.size());
        check_value("calib notice word", make_word(15'd3, 17'd0), d2p_q[0]);
        d2p_q.delete();
    endtask

    task test_config_relay;
        logic [31:0] train_word;
        int k;
        train_word = make_word(15'd2, 17'h1a5c3);
        @(negedge ui_clk);
        fifo_d2a_command_full = 1'b1;
        a2d_q.push_back(train_word);
        for (k = 0; k < 39; k++) begin
            p2d_cmd_q.push_back(config_word(k));
        end
        repeat (25) @(negedge ui_clk);
        check_value("config held while d2a full", 0, d2a_q.size());
        fifo_d2a_command_full = 1'b0;
        wait_items(SRC_D2A, 39, "configuration relay");
        wait_items(SRC_D2P, 1, "training done relay");
        for (k = 0; k < 39; k++) begin
            check_value($sformatf("config word %0d", k), config_word(k), d2a_q[k]);
        end
        check_value("config words before a2d pop", 39, a2d_pop_level);
        check_value("training done word", train_word, d2p_q[0]);
        d2a_q.delete();
        d2p_q.delete();
    endtask

    task test_addr_setup(input logic [31:0] base, input logic [31:0] last);
        @(negedge ui_clk);
        p2d_cmd_q.push_back(make_word(15'd4, {1'b0, base[15:0]}));
        p2d_cmd_q.push_back(make_word(15'd4, {1'b0, base[31:16]}));
        p2d_cmd_q.push_back(make_word(15'd4, {1'b0, last[15:0]}));
        p2d_cmd_q.push_back(make_word(15'd4, {1'b0, last[31:16]}));
        wait_items(SRC_D2P, 1, "address setup acknowledgement");
        check_value("address setup ack", make_word(15'd4, 17'd0), d2p_q[0]);
        d2p_q.delete();
    endtask

    task test_burst_write(input int n, input logic [31:0] base);
        logic [31:0] addr;
        int k;
        app_cmd_q.delete();
        app_addr_q.delete();
        app_data_q.delete();
        read_word = beat_pattern(200);
        test_addr_setup(base, base + 8 * (n - 1));
        for (k = 0; k < n; k++) begin
            p2d_data_q.push_back(beat_pattern(k));
        end
        wait_items(SRC_APP, n, "burst write");
        for (k = 0; k < n; k++) begin
            addr = base + 8 * k;
            check_value($sformatf("beat %0d command", k), 3'd0, app_cmd_q[k]);
            check_value($sformatf("beat %0d address", k), addr[28:0], app_addr_q[k]);
            check_value($sformatf("beat %0d data", k), beat_pattern(k), app_data_q[k]);
        end
    endtask

    task test_check_read(input int n, input logic [31:0] last);
        wait_items(SRC_APP, n + 1, "check read command");
        check_value("check read command", 3'd1, app_cmd_q[n]);
        check_value("check read address", last[28:0], app_addr_q[n]);
        wait_items(SRC_D2P, 1, "check report");
        check_value("check report", make_word(15'd5, {1'b0, read_word[15:0]}), d2p_q[0]);
        check_value("application command count", n + 1, app_cmd_q.size());
        d2p_q.delete();
    endtask

    task test_count_query(input int n);
        logic [31:0] total;
        total = 8 * n;
        @(negedge ui_clk);
        p2d_cmd_q.push_back(make_word(15'd6, 17'd0));
        wait_items(SRC_D2P, 1, "count query response");
        check_value("count query", make_word(15'd6, total[16:0]), d2p_q[0]);
        check_value("count query popped", 0, p2d_cmd_q.size());
        d2p_q.delete();
    endtask

    initial begin
        seed                   = 32'h6b25;
        errors                 = 0;
        d2a_total              = 0;
        a2d_pop_level          = -1;
        read_delay             = 0;
        read_word              = '0;
        reset                  = 1'b1;
        init_calib_complete    = 1'b0;
        fifo_p2d_command_dout  = '0;
        fifo_p2d_command_empty = 1'b1;
        fifo_p2d_command_valid = 1'b0;
        fifo_p2d_data_dout     = '0;
        fifo_p2d_data_empty    = 1'b1;
        fifo_p2d_data_valid    = 1'b0;
        fifo_a2d_command_dout  = '0;
        fifo_a2d_command_empty = 1'b1;
        fifo_a2d_command_valid = 1'b0;
        fifo_d2p_command_full  = 1'b0;
        fifo_d2a_command_full  = 1'b0;
        app_rdy                = 1'b0;
        app_wdf_rdy            = 1'b0;
        app_rd_data            = '0;
        app_rd_data_valid      = 1'b0;
        repeat (10) @(negedge ui_clk);
        reset = 1'b0;
        test_calib_notice();
        test_config_relay();
        // bits above the 29-bit application address are dropped
        test_burst_write(6, 32'ha000_0100);
        test_check_read(6, 32'ha000_0100 + 8 * 5);
        test_count_query(6);
        finish_run();
    end

endmodule
